// File: design/ospfb_pkg.sv
package ospfb_pkg;

  localparam int SAMPLE_W = 16;
  localparam int COEFF_W  = 8;
  localparam int ACC_W    = 24;
  localparam int OUT_W    = 18;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [COEFF_W-1:0]  coeff_t;
  typedef logic signed [ACC_W-1:0]    acc_t;
  typedef logic signed [OUT_W-1:0]    out_t;

  // output clamp limits
  localparam int OUT_MAX = (1 << (OUT_W - 1)) - 1;
  localparam int OUT_MIN = -(1 << (OUT_W - 1));

  typedef enum logic {
    COLLECT,
    COMPUTE
  } ctrl_state_t;

  // h[k] for flat tap index k = t*FFT_LEN+p
  function automatic coeff_t coeff_at(input int k);
    int h;
    h = ((3 * k) % 11) - 5;
    return coeff_t'(h);
  endfunction

endpackage

// File: design/ospfb_ifs.sv
`timescale 1ns/1ns

interface tap_if import ospfb_pkg::*; #(
  parameter int FFT_LEN = 8,
  parameter int PTAPS   = 2,
  localparam int BR_W   = $clog2(FFT_LEN)
);

  logic            valid;
  logic [BR_W-1:0] branch;
  logic            last;
  sample_t         taps [PTAPS];

  modport src (
    output valid, branch, last, taps
  );

  modport dst (
    input valid, branch, last, taps
  );

endinterface

// File: design/ospfb_ctrl.sv
`timescale 1ns/1ns

module ospfb_ctrl import ospfb_pkg::*; #(
  parameter int FFT_LEN = 8,
  parameter int DEC_FAC = 6,
  localparam int BR_W   = $clog2(FFT_LEN),
  localparam int CNT_W  = $clog2(DEC_FAC + 1)
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid,
  output logic            in_ready,
  output logic            shift_en,
  output logic            rd_valid,
  output logic [BR_W-1:0] rd_branch,
  output logic            rd_last,
  output logic            frame_start
);

  ctrl_state_t      state;
  logic [CNT_W-1:0] samp_cnt;
  logic [BR_W-1:0]  rot_shift;
  logic [BR_W-1:0]  rd_cnt;
  logic             accept;
  logic             frame_done;

  // modular add for branch indices with b at most FFT_LEN
  function automatic logic [BR_W-1:0] wrap_add(input logic [BR_W-1:0] a, input int b);
    int sum;
    sum = int'(a) + b;
    if (sum >= FFT_LEN) begin
      sum = sum - FFT_LEN;
    end
    return BR_W'(sum);
  endfunction

  // input only stalls while a frame is being read out
  assign in_ready   = (state == COLLECT);
  assign accept     = in_valid && in_ready;
  assign shift_en   = accept;
  assign frame_done = accept && (samp_cnt == CNT_W'(DEC_FAC - 1));

  assign rd_valid = (state == COMPUTE);
  assign rd_last  = rd_valid && (rd_cnt == BR_W'(FFT_LEN - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= COLLECT;
      samp_cnt    <= '0;
      rot_shift   <= '0;
      rd_cnt      <= '0;
      rd_branch   <= '0;
      frame_start <= 1'b0;
    end else begin
      frame_start <= 1'b0;
      case (state)
        COLLECT: begin
          if (frame_done) begin
            state       <= COMPUTE;
            samp_cnt    <= '0;
            rd_cnt      <= '0;
            // first branch issued is the rotation shift
            rd_branch   <= rot_shift;
            frame_start <= 1'b1;
          end else if (accept) begin
            samp_cnt <= samp_cnt + 1'b1;
          end
        end
        COMPUTE: begin
          rd_cnt    <= rd_cnt + 1'b1;
          rd_branch <= wrap_add(rd_branch, 1);
          if (rd_last) begin
            state     <= COLLECT;
            rot_shift <= wrap_add(rot_shift, DEC_FAC);
          end
        end
        default: state <= COLLECT;
      endcase
    end
  end

endmodule

// File: design/pfb_delay_line.sv
`timescale 1ns/1ns

module pfb_delay_line import ospfb_pkg::*; #(
  parameter int FFT_LEN = 8,
  parameter int PTAPS   = 2,
  localparam int BR_W   = $clog2(FFT_LEN),
  localparam int HIST   = FFT_LEN * PTAPS
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            shift_en,
  input  sample_t         in_data,
  input  logic            rd_valid,
  input  logic [BR_W-1:0] rd_branch,
  input  logic            rd_last,
  tap_if.src              taps
);

  // index 0 holds the newest sample
  sample_t hist [HIST];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < HIST; i++) begin
        hist[i] <= '0;
      end
    end else if (shift_en) begin
      hist[0] <= in_data;
      for (int i = 1; i < HIST; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      taps.valid <= 1'b0;
      taps.last  <= 1'b0;
    end else begin
      taps.valid <= rd_valid;
      taps.last  <= rd_valid && rd_last;
    end
  end

  // tap t sits FFT_LEN samples further back
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      taps.branch <= rd_branch;
      for (int t = 0; t < PTAPS; t++) begin
        taps.taps[t] <= hist[t*FFT_LEN + int'(rd_branch)];
      end
    end
  end

endmodule

// File: design/pfb_mac.sv
`timescale 1ns/1ns

module pfb_mac import ospfb_pkg::*; #(
  parameter int FFT_LEN = 8,
  parameter int PTAPS   = 2,
  localparam int NCOEF  = FFT_LEN * PTAPS
) (
  input  logic clk,
  input  logic rst_n,
  tap_if.dst   taps,
  output logic acc_valid,
  output acc_t acc,
  output logic acc_last
);

  coeff_t coef_tab [NCOEF];
  acc_t   prod [PTAPS];
  acc_t   sum;

  // fixed coefficient table
  for (genvar k = 0; k < NCOEF; k++) begin : g_coef
    assign coef_tab[k] = coeff_at(k);
  end

  always_comb begin
    for (int t = 0; t < PTAPS; t++) begin
      prod[t] = acc_t'(taps.taps[t]) * acc_t'(coef_tab[t*FFT_LEN + int'(taps.branch)]);
    end
  end

  // sum of the tap products
  always_comb begin
    sum = '0;
    for (int t = 0; t < PTAPS; t++) begin
      sum = sum + prod[t];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_valid <= 1'b0;
      acc_last  <= 1'b0;
    end else begin
      acc_valid <= taps.valid;
      acc_last  <= taps.valid && taps.last;
    end
  end

  always_ff @(posedge clk) begin
    if (taps.valid) begin
      acc <= sum;
    end
  end

endmodule

// File: design/pfb_out_stage.sv
`timescale 1ns/1ns

module pfb_out_stage import ospfb_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic acc_valid,
  input  acc_t acc,
  input  logic acc_last,
  output logic out_valid,
  output out_t out_data,
  output logic out_last,
  output logic out_sat
);

  logic clip_hi;
  logic clip_lo;

  assign clip_hi = (acc > acc_t'(OUT_MAX));
  assign clip_lo = (acc < acc_t'(OUT_MIN));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      out_sat   <= 1'b0;
    end else begin
      out_valid <= acc_valid;
      out_last  <= acc_valid && acc_last;
      out_sat   <= acc_valid && (clip_hi || clip_lo);
    end
  end

  always_ff @(posedge clk) begin
    if (acc_valid) begin
      if (clip_hi) out_data <= out_t'(OUT_MAX);
      else if (clip_lo) out_data <= out_t'(OUT_MIN);
      else out_data <= out_t'(acc);
    end
  end

endmodule

// File: design/ospfb_top.sv
`timescale 1ns/1ns

module ospfb_top import ospfb_pkg::*; #(
  parameter int FFT_LEN = 8,
  parameter int DEC_FAC = 6,
  parameter int PTAPS   = 2,
  localparam int BR_W   = $clog2(FFT_LEN)
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid,
  input  sample_t in_data,
  output logic    in_ready,
  output logic    out_valid,
  output out_t    out_data,
  output logic    out_last,
  output logic    out_sat,
  output logic    frame_start
);

  logic            shift_en;
  logic            rd_valid;
  logic [BR_W-1:0] rd_branch;
  logic            rd_last;
  logic            acc_valid;
  acc_t            acc;
  logic            acc_last;

  tap_if #(.FFT_LEN(FFT_LEN), .PTAPS(PTAPS)) tap_bus ();

  ospfb_ctrl #(
    .FFT_LEN(FFT_LEN),
    .DEC_FAC(DEC_FAC)
  ) i_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .shift_en   (shift_en),
    .rd_valid   (rd_valid),
    .rd_branch  (rd_branch),
    .rd_last    (rd_last),
    .frame_start(frame_start)
  );

  pfb_delay_line #(
    .FFT_LEN(FFT_LEN),
    .PTAPS  (PTAPS)
  ) i_delay_line (
    .clk      (clk),
    .rst_n    (rst_n),
    .shift_en (shift_en),
    .in_data  (in_data),
    .rd_valid (rd_valid),
    .rd_branch(rd_branch),
    .rd_last  (rd_last),
    .taps     (tap_bus.src)
  );

  pfb_mac #(
    .FFT_LEN(FFT_LEN),
    .PTAPS  (PTAPS)
  ) i_mac (
    .clk      (clk),
    .rst_n    (rst_n),
    .taps     (tap_bus.dst),
    .acc_valid(acc_valid),
    .acc      (acc),
    .acc_last (acc_last)
  );

  pfb_out_stage i_out_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .acc_valid(acc_valid),
    .acc      (acc),
    .acc_last (acc_last),
    .out_valid(out_valid),
    .out_data (out_data),
    .out_last (out_last),
    .out_sat  (out_sat)
  );

endmodule

// File: bench/ospfb_sva.sv
`timescale 1ns/1ns

module ospfb_sva (
  input logic clk,
  input logic rst_n,
  input logic in_ready,
  input logic out_valid,
  input logic out_last,
  input logic out_sat,
  input logic frame_start
);

  // first output of a pass comes while the input is stalled
  a_out_stall: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(out_valid) |-> !in_ready) else $error("output began with in_ready high");

  a_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
    out_last |-> out_valid) else $error("out_last without out_valid");

  a_sat_valid: assert property (@(posedge clk) disable iff (!rst_n)
    out_sat |-> out_valid) else $error("out_sat without out_valid");

  a_start_out: assert property (@(posedge clk) disable iff (!rst_n)
    frame_start |-> ##[1:4] out_valid) else $error("no output after frame_start");

endmodule

bind ospfb_top ospfb_sva i_sva (.*);

// File: bench/ospfb_tb.sv
`timescale 1ns/1ns

module ospfb_tb import ospfb_pkg::*; ();

  localparam int FFT_LEN    = 8;
  localparam int DEC_FAC    = 6;
  localparam int PTAPS      = 2;
  localparam int WAIT_LIMIT = 500;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    in_valid;
  sample_t in_data;
  logic    in_ready;
  logic    out_valid;
  out_t    out_data;
  logic    out_last;
  logic    out_sat;
  logic    frame_start;

  // accepted samples since the last reset, oldest first
  int hist_q[$];
  int exp_data[FFT_LEN];
  bit exp_sat[FFT_LEN];
  int stall = 0;
  int beat = 0;
  int frame = 0;
  int frames_done = 0;
  int sat_seen = 0;

  ospfb_top #(.FFT_LEN(FFT_LEN), .DEC_FAC(DEC_FAC), .PTAPS(PTAPS)) i_ospfb_top (.*);

  always #50 clk = ~clk;

  task automatic stop_run();
    $display("Test failures found");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_value(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      stop_run();
    end
  endtask

  // fills exp_data and exp_sat for frame f counted from the last reset
  function automatic void ref_frame(input int f);
    int n;
    int s;
    int p;
    int k;
    int idx;
    int sum;
    n = (f + 1) * DEC_FAC;
    s = (f * DEC_FAC) % FFT_LEN;
    for (int q = 0; q < FFT_LEN; q++) begin
      p = (q + s) % FFT_LEN;
      sum = 0;
      for (int t = 0; t < PTAPS; t++) begin
        k = t * FFT_LEN + p;
        idx = n - 1 - k;
        // taps older than the first sample are zero
        if (idx >= 0) begin
          sum += hist_q[idx] * (((3 * k) % 11) - 5);
        end
      end
      exp_sat[q] = (sum > 131071) || (sum < -131072);
      exp_data[q] = (sum > 131071) ? 131071 : ((sum < -131072) ? -131072 : sum);
    end
  endfunction

  // mirror accepted samples and predict in_ready and frame_start
  always @(posedge clk) begin
    if (!rst_n) begin
      hist_q.delete();
      stall = 0;
    end else begin
      check_value(int'(in_ready), int'(stall == 0), "in_ready");
      // a pass begins one cycle after the last sample of its frame
      check_value(int'(frame_start), int'(stall == FFT_LEN), "frame_start");
      if (stall > 0) begin
        stall--;
      end
      if (in_valid && in_ready) begin
        hist_q.push_back(int'(in_data));
        // one pass of FFT_LEN reads follows every full frame
        if (hist_q.size() % DEC_FAC == 0) begin
          stall = FFT_LEN;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      beat = 0;
      frame = 0;
    end else if (out_valid) begin
      if (beat == 0) begin
        ref_frame(frame);
      end
      check_value(int'(out_data), exp_data[beat], "out_data");
      check_value(int'(out_sat), int'(exp_sat[beat]), "out_sat");
      check_value(int'(out_last), int'(beat == FFT_LEN - 1), "out_last");
      if (out_sat) begin
        sat_seen++;
      end
      beat++;
      if (beat == FFT_LEN) begin
        beat = 0;
        frame++;
        frames_done++;
      end
    end
  end

  task automatic send_sample(input int v, input int max_gap);
    int waited;
    if (max_gap > 0) begin
      in_valid <= 1'b0;
      repeat ($urandom_range(max_gap, 0)) @(posedge clk);
    end
    in_valid <= 1'b1;
    in_data  <= sample_t'(v);
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: sample %0d was never accepted, in_ready stayed low", v);
        stop_run();
      end
    end while (!in_ready);
  endtask

  task automatic send_frames(input int count, input bit full_scale, input int max_gap);
    int v;
    for (int i = 0; i < count * DEC_FAC; i++) begin
      if (full_scale) begin
        v = $urandom_range(1, 0) ? 32767 : -32768;
      end else begin
        v = int'($urandom_range(200, 0)) - 100;
      end
      send_sample(v, max_gap);
    end
    in_valid <= 1'b0;
  endtask

  task automatic wait_frames(input int target);
    int waited;
    waited = 0;
    while (frames_done < target) begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: output frame %0d never completed", target);
        stop_run();
      end
    end
  endtask

  initial begin
    int base;
    void'($urandom(32'hb069));
    rst_n    <= 1'b0;
    in_valid <= 1'b0;
    in_data  <= '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    // start from empty history and run through every shift
    send_frames(FFT_LEN + 2, 1'b0, 0);
    wait_frames(FFT_LEN + 2);
    send_frames(4, 1'b0, 3);
    wait_frames(FFT_LEN + 6);
    // full scale pushes sums past the output range
    send_frames(4, 1'b1, 1);
    wait_frames(FFT_LEN + 10);
    check_value(int'(sat_seen > 0), 1, "saturated outputs seen");
    // reset in the middle of a pass
    base = frames_done;
    send_frames(1, 1'b0, 0);
    repeat (3) @(posedge clk);
    rst_n <= 1'b0;
    @(posedge clk);
    check_value(int'(in_ready), 1, "in_ready during reset");
    repeat (9) @(posedge clk);
    rst_n <= 1'b1;
    send_frames(3, 1'b0, 2);
    wait_frames(base + 3);
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: filelist.f
design/ospfb_pkg.sv
design/ospfb_ifs.sv
design/ospfb_ctrl.sv
design/pfb_delay_line.sv
design/pfb_mac.sv
design/pfb_out_stage.sv
design/ospfb_top.sv
bench/ospfb_sva.sv
bench/ospfb_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ospfb_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# build and run, a failing run exits with a nonzero status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
